// ==== Bender.yml ====
package:
  name: pkt_monitor

sources:
  # Design sources in compile order
  - files:
      - design/pkt_monitor_pkg.sv
      - design/pkt_lane_if.sv
      - design/pkt_ingress.sv
      - design/core_pkt_classifier.sv
      - design/stats_collector.sv
      - design/pkt_monitor_top.sv
  # Testbench and bound assertions
  - target: test
    files:
      - tests/pkt_monitor_assert.sv
      - tests/pkt_monitor_tb.sv

// ==== design/core_pkt_classifier.sv ====
module core_pkt_classifier #(
   parameter int CNT_W = 16
) (
   input  logic   clk,
   input  logic   rst,
   lane_if.lane   lane,
   stat_if.lane   stats
);
   import pkt_monitor_pkg::*;

   localparam logic [CNT_W-1:0] CNT_MAX = '1;

   // Request type to counter class
   function automatic pcx_class_e pcx_class(input req_type_t rq);
      case (rq)
         load_rq, imiss_rq, strload_rq: pcx_class = load_cls;
         store_rq, strst_rq, stq_rq:    pcx_class = store_cls;
         cas1_rq, cas2_rq, swap_rq:     pcx_class = atomic_cls;
         default:                       pcx_class = other_cls;
      endcase
   endfunction

   // Return type to counter class
   function automatic cpx_class_e cpx_class(input ret_type_t rq);
      case (rq)
         load_ret, ifill_ret, strload_ret: cpx_class = fill_cls;
         st_ack, at_ack, strst_ack:        cpx_class = ack_cls;
         int_ret:                          cpx_class = intr_cls;
         default:                          cpx_class = misc_cls;
      endcase
   endfunction

   // Counters stop at all ones instead of wrapping
   function automatic logic [CNT_W-1:0] sat_inc(input logic [CNT_W-1:0] cnt);
      if (cnt == CNT_MAX) begin
         sat_inc = cnt;
      end else begin
         sat_inc = cnt + 1'b1;
      end
   endfunction

   logic                        pcx_fire;
   logic                        cpx_fire;
   logic                        intr_fire;
   pcx_class_e                  pcx_cls;
   cpx_class_e                  cpx_cls;
   intr_rec_t                   intr;
   logic [3:0][CNT_W-1:0]       pcx_cnt_q;
   logic [3:0][CNT_W-1:0]       cpx_cnt_q;
   logic [THREADS_PER_CORE-1:0] active_q;
   logic [THREADS_PER_CORE-1:0] back_q;

   // A valid word only counts when a strobe came the cycle before it
   assign pcx_fire = lane.req_seen && lane.pcx.valid;
   // cpx_hit already folds in the valid bit and the destination match
   assign cpx_fire = lane.cpx_hit;
   assign pcx_cls  = pcx_class(lane.pcx.rq);
   assign cpx_cls  = cpx_class(lane.cpx.rq);

   // Interrupt returns carry a thread record in the body
   assign intr      = lane.cpx.body.intr;
   assign intr_fire = cpx_fire && (lane.cpx.rq == int_ret);

   always_ff @(posedge clk) begin
      if (rst) begin
         pcx_cnt_q <= '0;
         cpx_cnt_q <= '0;
      end else begin
         // Request and return sides can both count in the same cycle
         if (pcx_fire) begin
            pcx_cnt_q[pcx_cls] <= sat_inc(pcx_cnt_q[pcx_cls]);
         end
         if (cpx_fire) begin
            cpx_cnt_q[cpx_cls] <= sat_inc(cpx_cnt_q[cpx_cls]);
         end
      end
   end

   // Thread tracking
   // Kind 1 wakes a thread and marks it back if it was awake already
   // Kind 3 only marks an awake thread as back
   always_ff @(posedge clk) begin
      if (rst) begin
         active_q <= '0;
         back_q   <= '0;
      end else if (intr_fire) begin
         case (intr.kind)
            2'd1: begin
               if (active_q[intr.thr]) begin
                  back_q[intr.thr] <= 1'b1;
               end
               active_q[intr.thr] <= 1'b1;
            end
            2'd3: begin
               if (active_q[intr.thr]) begin
                  back_q[intr.thr] <= 1'b1;
               end
            end
            // Kinds 0 and 2 leave both flags alone
            default: begin
            end
         endcase
      end
   end

   assign stats.pcx_cnt = pcx_cnt_q;
   assign stats.cpx_cnt = cpx_cnt_q;
   assign stats.active  = active_q;
   assign stats.back    = back_q;

endmodule

// ==== design/pkt_ingress.sv ====
module pkt_ingress #(
   parameter int NUM_CORES = 4
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic [4:0]                 pcx_req [NUM_CORES],
   input  pkt_monitor_pkg::pcx_pkt_t  pcx_data [NUM_CORES],
   input  pkt_monitor_pkg::cpx_pkt_t  cpx_data,
   lane_if.ingress                    lanes [NUM_CORES]
);
   import pkt_monitor_pkg::*;

   // The return bus is shared, so one register serves every lane
   cpx_pkt_t cpx_q;

   always_ff @(posedge clk) begin
      cpx_q <= cpx_data;
   end

   for (genvar c = 0; c < NUM_CORES; c++) begin : g_lane
      // Strobe of the previous cycle, which qualifies the word of this cycle
      logic strobe_q;

      always_ff @(posedge clk) begin
         if (rst) begin
            strobe_q          <= 1'b0;
            lanes[c].req_seen <= 1'b0;
            lanes[c].cpx_hit  <= 1'b0;
         end else begin
            // Any of the five request lines counts as a strobe
            strobe_q          <= |pcx_req[c];
            // Moves with the word so both reach the classifier together
            lanes[c].req_seen <= strobe_q;
            // Returns to a core that does not exist match no lane and are dropped
            lanes[c].cpx_hit  <= cpx_data.valid && (32'(cpx_data.dest) == c);
         end
      end

      // Request word, qualified downstream by req_seen
      always_ff @(posedge clk) begin
         lanes[c].pcx <= pcx_data[c];
      end

      assign lanes[c].cpx = cpx_q;
   end

endmodule

// ==== design/pkt_lane_if.sv ====
// One core's view of the traffic after the ingress register stage
interface lane_if;
   import pkt_monitor_pkg::*;

   // Strobe seen in the cycle before the word in pcx
   logic     req_seen;
   pcx_pkt_t pcx;
   // Set when the return in cpx is valid and addressed to this core
   logic     cpx_hit;
   cpx_pkt_t cpx;

   modport ingress (
      output req_seen,
      output pcx,
      output cpx_hit,
      output cpx
   );

   modport lane (
      input req_seen,
      input pcx,
      input cpx_hit,
      input cpx
   );
endinterface

// Statistics of one core, indexed by class
interface stat_if #(
   parameter int CNT_W = 16
);
   import pkt_monitor_pkg::*;

   logic [3:0][CNT_W-1:0]            pcx_cnt;
   logic [3:0][CNT_W-1:0]            cpx_cnt;
   logic [THREADS_PER_CORE-1:0]      active;
   logic [THREADS_PER_CORE-1:0]      back;

   modport lane (
      output pcx_cnt,
      output cpx_cnt,
      output active,
      output back
   );

   modport collector (
      input pcx_cnt,
      input cpx_cnt,
      input active,
      input back
   );
endinterface

// ==== design/pkt_monitor_pkg.sv ====
package pkt_monitor_pkg;

   // Hardware threads served by one core
   localparam int THREADS_PER_CORE = 4;

   // Request type codes as they appear on the core-to-cache side
   typedef enum logic [4:0] {
      load_rq    = 5'b00000,
      store_rq   = 5'b00001,
      cas1_rq    = 5'b00010,
      cas2_rq    = 5'b00011,
      strload_rq = 5'b00100,
      strst_rq   = 5'b00101,
      swap_rq    = 5'b00110,
      stq_rq     = 5'b00111,
      int_rq     = 5'b01001,
      fpop1_rq   = 5'b01010,
      fpop2_rq   = 5'b01011,
      fwd_rq     = 5'b01101,
      fwd_rpy    = 5'b01110,
      imiss_rq   = 5'b10000,
      rsvd_rq    = 5'b11111
   } req_type_t;

   // Request word, valid bit on top
   typedef struct packed {
      logic      valid;
      req_type_t rq;
      logic [9:0] payload;
   } pcx_pkt_t;

   // Return type codes on the shared cache-to-core bus
   typedef enum logic [3:0] {
      load_ret    = 4'b0000,
      ifill_ret   = 4'b0001,
      strload_ret = 4'b0010,
      inv_ret     = 4'b0011,
      st_ack      = 4'b0100,
      at_ack      = 4'b0101,
      strst_ack   = 4'b0110,
      int_ret     = 4'b0111,
      fp_ret      = 4'b1000,
      test_ret    = 4'b1001,
      fwd_rq_ret  = 4'b1010,
      fwd_rpy_ret = 4'b1011,
      err_ret     = 4'b1100,
      evict_req   = 4'b1101,
      rsvd_ret    = 4'b1111
   } ret_type_t;

   // Interrupt view of a return body
   // The thread number sits in bits 9:8 and the core in bits 12:10
   typedef struct packed {
      logic [1:0] kind;
      logic [2:0] rsvd_hi;
      logic [2:0] cpu;
      logic [1:0] thr;
      logic [1:0] rsvd_lo;
      logic [5:0] vector;
   } intr_rec_t;

   // The same 18 bits read either as plain data or as an interrupt record
   typedef union packed {
      logic [17:0] raw;
      intr_rec_t   intr;
   } cpx_body_u;

   typedef struct packed {
      logic      valid;
      ret_type_t rq;
      logic [2:0] dest;
      cpx_body_u body;
   } cpx_pkt_t;

   // Counter classes, also used as counter indices
   typedef enum logic [1:0] {
      load_cls   = 2'd0,
      store_cls  = 2'd1,
      atomic_cls = 2'd2,
      other_cls  = 2'd3
   } pcx_class_e;

   typedef enum logic [1:0] {
      fill_cls = 2'd0,
      ack_cls  = 2'd1,
      intr_cls = 2'd2,
      misc_cls = 2'd3
   } cpx_class_e;

   // Read selector: bit 3 clear picks a counter, bit 2 picks the return side
   typedef enum logic [3:0] {
      sel_pcx_load   = 4'd0,
      sel_pcx_store  = 4'd1,
      sel_pcx_atomic = 4'd2,
      sel_pcx_other  = 4'd3,
      sel_cpx_fill   = 4'd4,
      sel_cpx_ack    = 4'd5,
      sel_cpx_intr   = 4'd6,
      sel_cpx_misc   = 4'd7,
      sel_active     = 4'd8,
      sel_back       = 4'd9
   } rd_sel_e;

endpackage

// ==== design/pkt_monitor_top.sv ====
module pkt_monitor_top #(
   parameter int NUM_CORES = 4,
   parameter int CNT_W     = 16
) (
   input  logic                      clk,
   input  logic                      rst,
   input  logic [4:0]                pcx_req [NUM_CORES],
   input  pkt_monitor_pkg::pcx_pkt_t pcx_data [NUM_CORES],
   input  pkt_monitor_pkg::cpx_pkt_t cpx_data,
   input  logic                      rd_en,
   input  logic [2:0]                rd_core,
   input  pkt_monitor_pkg::rd_sel_e  rd_sel,
   output logic                      rd_vld,
   output logic [CNT_W-1:0]          rd_data
);

   // One lane and one statistics bundle per core
   lane_if                    lane_bus [NUM_CORES] ();
   stat_if #(.CNT_W(CNT_W))   stat_bus [NUM_CORES] ();

   // Aligns each strobe with its word and steers returns by dest
   pkt_ingress #(
      .NUM_CORES(NUM_CORES)
   ) u_ingress (
      .clk      (clk),
      .rst      (rst),
      .pcx_req  (pcx_req),
      .pcx_data (pcx_data),
      .cpx_data (cpx_data),
      .lanes    (lane_bus)
   );

   for (genvar c = 0; c < NUM_CORES; c++) begin : g_core
      core_pkt_classifier #(
         .CNT_W(CNT_W)
      ) u_classifier (
         .clk   (clk),
         .rst   (rst),
         .lane  (lane_bus[c]),
         .stats (stat_bus[c])
      );
   end

   // Register read port over all lanes
   stats_collector #(
      .NUM_CORES(NUM_CORES),
      .CNT_W    (CNT_W)
   ) u_collector (
      .clk     (clk),
      .rst     (rst),
      .stats   (stat_bus),
      .rd_en   (rd_en),
      .rd_core (rd_core),
      .rd_sel  (rd_sel),
      .rd_vld  (rd_vld),
      .rd_data (rd_data)
   );

endmodule

// ==== design/stats_collector.sv ====
module stats_collector #(
   parameter int NUM_CORES = 4,
   parameter int CNT_W     = 16
) (
   input  logic                     clk,
   input  logic                     rst,
   stat_if.collector                stats [NUM_CORES],
   input  logic                     rd_en,
   input  logic [2:0]               rd_core,
   input  pkt_monitor_pkg::rd_sel_e rd_sel,
   output logic                     rd_vld,
   output logic [CNT_W-1:0]         rd_data
);
   import pkt_monitor_pkg::*;

   // Selected field of every lane, before the core select
   logic [CNT_W-1:0] lane_val [NUM_CORES];
   logic [CNT_W-1:0] sel_val;

   // Interface arrays only take constant indices, so each lane muxes its own field
   for (genvar c = 0; c < NUM_CORES; c++) begin : g_field
      always_comb begin
         lane_val[c] = '0;
         case (rd_sel)
            // Thread flags are zero extended to the counter width
            sel_active: lane_val[c] = CNT_W'(stats[c].active);
            sel_back:   lane_val[c] = CNT_W'(stats[c].back);
            default: begin
               // Bit 2 picks the return side and bits 1:0 the class
               if (!rd_sel[3]) begin
                  if (rd_sel[2]) begin
                     lane_val[c] = stats[c].cpx_cnt[rd_sel[1:0]];
                  end else begin
                     lane_val[c] = stats[c].pcx_cnt[rd_sel[1:0]];
                  end
               end
            end
         endcase
      end
   end

   // A core number past the last lane matches nothing and reads zero
   always_comb begin
      sel_val = '0;
      for (int c = 0; c < NUM_CORES; c++) begin
         if (32'(rd_core) == c) begin
            sel_val = lane_val[c];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_vld <= 1'b0;
      end else begin
         rd_vld <= rd_en;
      end
   end

   // Sampled in the rd_en cycle so the answer matches that cycle's counts
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_data <= sel_val;
      end
   end

endmodule

// ==== files.f ====
design/pkt_monitor_pkg.sv
design/pkt_lane_if.sv
design/pkt_ingress.sv
design/core_pkt_classifier.sv
design/stats_collector.sv
design/pkt_monitor_top.sv
tests/pkt_monitor_assert.sv
tests/pkt_monitor_tb.sv

// ==== tests/pkt_monitor_assert.sv ====
module pkt_monitor_assert #(
   parameter int NUM_CORES = 4
) (
   input  logic      clk,
   input  logic      rst,
   input  logic      rd_en,
   input  logic      rd_vld,
   stat_if.collector stats [NUM_CORES]
);
   timeunit 1ns;
   timeprecision 100ps;

   // Number of failed assertions over the run
   int unsigned fail_cnt = 0;

   // A read answers in the very next cycle
   rd_vld_follows_en: assert property (@(posedge clk) disable iff (rst) rd_en |=> rd_vld)
      else begin
         fail_cnt++;
         $error("rd_vld did not follow rd_en by one cycle");
      end

   // No answer without a read one cycle before it
   rd_vld_only_after_en: assert property (@(posedge clk) disable iff (rst) !rd_en |=> !rd_vld)
      else begin
         fail_cnt++;
         $error("rd_vld high without rd_en in the cycle before");
      end

   // Reset holds the read port quiet
   rd_vld_low_in_reset: assert property (@(posedge clk) rst |=> !rd_vld)
      else begin
         fail_cnt++;
         $error("rd_vld high during reset");
      end

   // A thread can only be marked back once it has been woken
   for (genvar c = 0; c < NUM_CORES; c++) begin : g_flags
      back_needs_active: assert property (@(posedge clk) disable iff (rst)
         (stats[c].back & ~stats[c].active) == '0)
         else begin
            fail_cnt++;
            $error("Back flag set on an inactive thread of core %0d", c);
         end
   end

endmodule

bind stats_collector pkt_monitor_assert #(
   .NUM_CORES(NUM_CORES)
) u_assert (
   .clk    (clk),
   .rst    (rst),
   .rd_en  (rd_en),
   .rd_vld (rd_vld),
   .stats  (stats)
);

// ==== tests/pkt_monitor_tb.sv ====
module pkt_monitor_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import pkt_monitor_pkg::*;

   localparam int NUM_CORES = 4;
   localparam int CNT_W     = 16;
   // Negedges to wait for a read answer before giving up
   localparam int TIMEOUT   = 20;

   logic                      clk;
   logic                      rst;
   logic [4:0]                pcx_req [NUM_CORES];
   pcx_pkt_t                  pcx_data [NUM_CORES];
   cpx_pkt_t                  cpx_data;
   logic                      rd_en;
   logic [2:0]                rd_core;
   rd_sel_e                   rd_sel;
   logic                      rd_vld;
   logic [CNT_W-1:0]          rd_data;

   int unsigned               lcg_state = 1;
   int                        errors;
   int                        timeouts;

   // Reference counts, kept unbounded and clipped when compared
   int                        exp_pcx [NUM_CORES][4];
   int                        exp_cpx [NUM_CORES][4];
   logic [THREADS_PER_CORE-1:0] exp_act [NUM_CORES];
   logic [THREADS_PER_CORE-1:0] exp_back [NUM_CORES];

   // Every named request code, walked from a random start in the request test
   req_type_t req_codes [15] = '{load_rq, store_rq, cas1_rq, cas2_rq, strload_rq,
                                 strst_rq, swap_rq, stq_rq, int_rq, fpop1_rq,
                                 fpop2_rq, fwd_rq, fwd_rpy, imiss_rq, rsvd_rq};

   pkt_monitor_top #(
      .NUM_CORES(NUM_CORES),
      .CNT_W    (CNT_W)
   ) dut0 (
      .clk      (clk),
      .rst      (rst),
      .pcx_req  (pcx_req),
      .pcx_data (pcx_data),
      .cpx_data (cpx_data),
      .rd_en    (rd_en),
      .rd_core  (rd_core),
      .rd_sel   (rd_sel),
      .rd_vld   (rd_vld),
      .rd_data  (rd_data)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic int unsigned next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state >> 16;
   endfunction

   // Class index of a request code, same order as read selectors 0 to 3
   function automatic int req_class(input logic [4:0] code);
      if (code inside {load_rq, imiss_rq, strload_rq}) return 0;
      if (code inside {store_rq, strst_rq, stq_rq}) return 1;
      if (code inside {cas1_rq, cas2_rq, swap_rq}) return 2;
      return 3;
   endfunction

   // Class index of a return code, same order as read selectors 4 to 7
   function automatic int ret_class(input logic [3:0] code);
      if (code inside {load_ret, ifill_ret, strload_ret}) return 0;
      if (code inside {st_ack, at_ack, strst_ack}) return 1;
      if (code == int_ret) return 2;
      return 3;
   endfunction

   function automatic logic [CNT_W-1:0] clip(input int n);
      if (n >= 2**CNT_W - 1) begin
         return '1;
      end
      return CNT_W'(n);
   endfunction

   // Updates the reference for one return as it goes onto the bus
   function automatic void model_ret(input cpx_pkt_t p);
      int d;
      int t;
      d = int'(p.dest);
      t = int'(p.body.intr.thr);
      if (p.valid && d < NUM_CORES) begin
         exp_cpx[d][ret_class(p.rq)]++;
         if (p.rq == int_ret) begin
            // Kind 1 wakes, kind 3 marks an awake thread back
            if (p.body.intr.kind == 2'd1) begin
               if (exp_act[d][t]) begin
                  exp_back[d][t] = 1'b1;
               end
               exp_act[d][t] = 1'b1;
            end else if (p.body.intr.kind == 2'd3 && exp_act[d][t]) begin
               exp_back[d][t] = 1'b1;
            end
         end
      end
   endfunction

   task automatic check_count(input string name, input logic [CNT_W-1:0] got,
                              input logic [CNT_W-1:0] exp);
      if (got !== exp) begin
         errors++;
         $display("** Error: %s = %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_flags(input string name, input logic [THREADS_PER_CORE-1:0] got,
                              input logic [THREADS_PER_CORE-1:0] exp);
      if (got !== exp) begin
         errors++;
         $display("** Error: %s = %h, expected %h", name, got, exp);
      end
   endtask

   // One register read; waited tells how many negedges the answer was late
   task automatic read_reg(input int core, input int sel, output logic [CNT_W-1:0] data,
                           output int waited);
      int n;
      @(posedge clk);
      rd_en   <= 1'b1;
      rd_core <= 3'(core);
      rd_sel  <= rd_sel_e'(sel);
      @(posedge clk);
      rd_en   <= 1'b0;
      n = 0;
      @(negedge clk);
      while (!rd_vld && n < TIMEOUT) begin
         n++;
         @(negedge clk);
      end
      waited = n;
      if (rd_vld !== 1'b1) begin
         timeouts++;
         $display("Timeout: read of core %0d selector %0d got no answer", core, sel);
         data = 'x;
      end else begin
         data = rd_data;
      end
   endtask

   // Reads all counters and flags of one core against the reference
   task automatic check_core(input int c);
      logic [CNT_W-1:0] d;
      int               w;
      for (int k = 0; k < 4; k++) begin
         read_reg(c, k, d, w);
         check_count($sformatf("core%0d pcx_cnt[%0d]", c, k), d, clip(exp_pcx[c][k]));
         read_reg(c, k + 4, d, w);
         check_count($sformatf("core%0d cpx_cnt[%0d]", c, k), d, clip(exp_cpx[c][k]));
      end
      read_reg(c, 8, d, w);
      check_flags($sformatf("core%0d active", c), d[3:0], exp_act[c]);
      check_count($sformatf("core%0d active upper bits", c), d >> 4, '0);
      read_reg(c, 9, d, w);
      check_flags($sformatf("core%0d back", c), d[3:0], exp_back[c]);
      check_count($sformatf("core%0d back upper bits", c), d >> 4, '0);
   endtask

   task automatic check_all();
      logic [CNT_W-1:0] d;
      int               w;
      for (int c = 0; c < NUM_CORES; c++) begin
         check_core(c);
      end
      // Core numbers past the last lane read zero
      read_reg(NUM_CORES + int'(next_rand() % (8 - NUM_CORES)), 0, d, w);
      check_count("rd_data of absent core", d, '0);
   endtask

   // Quiets the inputs and lets the two pipeline stages settle
   task automatic settle();
      @(posedge clk);
      cpx_data <= '0;
      for (int c = 0; c < NUM_CORES; c++) begin
         pcx_req[c]  <= '0;
         pcx_data[c] <= '0;
      end
      repeat (3) @(posedge clk);
   endtask

   // Strobe in one cycle, word in the next, with or without the strobe
   task automatic send_req(input int core, input logic [4:0] code, input bit strobe);
      pcx_pkt_t w;
      w.valid   = 1'b1;
      w.rq      = req_type_t'(code);
      w.payload = 10'(next_rand());
      @(posedge clk);
      pcx_req[core]        <= strobe ? 5'(1 << (next_rand() % 5)) : 5'b0;
      pcx_data[core].valid <= 1'b0;
      @(posedge clk);
      pcx_req[core]  <= 5'b0;
      pcx_data[core] <= w;
      @(posedge clk);
      pcx_data[core] <= '0;
      if (strobe) begin
         exp_pcx[core][req_class(code)]++;
      end
   endtask

   task automatic send_ret(input int dest, input logic [3:0] code, input cpx_body_u body);
      cpx_pkt_t p;
      p.valid = 1'b1;
      p.rq    = ret_type_t'(code);
      p.dest  = 3'(dest);
      p.body  = body;
      @(posedge clk);
      cpx_data <= p;
      model_ret(p);
   endtask

   task automatic send_intr(input int dest, input int kind, input int thr);
      cpx_body_u b;
      b.raw         = '0;
      b.intr.kind   = 2'(kind);
      b.intr.cpu    = 3'(dest);
      b.intr.thr    = 2'(thr);
      b.intr.vector = 6'(next_rand());
      send_ret(dest, int_ret, b);
   endtask

   task automatic test_reset_state();
      logic [CNT_W-1:0] d;
      int               w;
      check_all();
      read_reg(1, 0, d, w);
      if (w != 0) begin
         errors++;
         $display("Read answer came %0d cycles late", w);
      end
      @(negedge clk);
      if (rd_vld !== 1'b0) begin
         errors++;
         $display("rd_vld stayed high for more than one cycle");
      end
   endtask

   task automatic test_requests();
      int start;
      start = int'(next_rand() % 15);
      for (int c = 0; c < NUM_CORES; c++) begin
         for (int i = 0; i < 15; i++) begin
            send_req(c, req_codes[(start + i) % 15], 1'b1);
         end
         // One code picked at random, named or not
         send_req(c, 5'(next_rand()), 1'b1);
      end
      settle();
      check_all();
      // Words without a strobe must not move anything
      for (int c = 0; c < NUM_CORES; c++) begin
         for (int i = 0; i < 15; i++) begin
            send_req(c, req_codes[i], 1'b0);
         end
      end
      settle();
      check_all();
   endtask

   task automatic test_returns();
      cpx_body_u b;
      for (int i = 0; i < 60; i++) begin
         b.raw = 18'(next_rand());
         // Dest spans all eight codes so some land beyond the last core
         send_ret(int'(next_rand() % 8), 4'(next_rand()), b);
      end
      settle();
      check_all();
   endtask

   task automatic test_interrupts();
      for (int c = 0; c < NUM_CORES; c += 3) begin
         send_intr(c, 3, 1);
         send_intr(c, 1, 0);
         send_intr(c, 1, 0);
         send_intr(c, 1, 1);
         send_intr(c, 3, 1);
         send_intr(c, 0, 2);
         send_intr(c, 2, 2);
         send_intr(c, 3, 3);
      end
      // Out of range, so thread 2 of no core wakes
      send_intr(NUM_CORES, 1, 2);
      settle();
      check_all();
   endtask

   task automatic test_saturation();
      int n;
      n = 2**CNT_W + 5;
      @(posedge clk);
      pcx_req[2] <= 5'b00001;
      for (int i = 0; i < n; i++) begin
         @(posedge clk);
         pcx_data[2] <= '{valid: 1'b1, rq: load_rq, payload: 10'(i)};
      end
      exp_pcx[2][0] += n;
      settle();
      check_all();
   endtask

   initial begin
      rst      = 1'b1;
      rd_en    = 1'b0;
      rd_core  = '0;
      rd_sel   = sel_pcx_load;
      cpx_data = '0;
      errors   = 0;
      timeouts = 0;
      for (int c = 0; c < NUM_CORES; c++) begin
         pcx_req[c]  = '0;
         pcx_data[c] = '0;
         exp_act[c]  = '0;
         exp_back[c] = '0;
         for (int k = 0; k < 4; k++) begin
            exp_pcx[c][k] = 0;
            exp_cpx[c][k] = 0;
         end
      end
      repeat (4) @(posedge clk);
      rst <= 1'b0;

      test_reset_state();
      test_requests();
      test_returns();
      test_interrupts();
      test_saturation();

      $display("Errors: %0d value mismatches, %0d timeouts, %0d assertion failures",
               errors, timeouts, dut0.u_collector.u_assert.fail_cnt);
      if (errors == 0 && timeouts == 0 && dut0.u_collector.u_assert.fail_cnt == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule
